// File: include/exec_defines.svh
// sizes shared by the execute cluster.
// slot and unit counts are fixed at four, since the unit one-hot order is hard wired.
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// data path width.
`define XLEN 32

// rob tag width.
`define ROB_W 4

// ready reservation-station slots seen by the scheduler.
`define NUM_SLOTS 4

// functional units in the cluster.
`define NUM_FU 4

`endif

// File: verilog/isa_pkg.sv
// operation and branch condition encodings for the execute cluster.
// the top two opcode bits are the class and the low bit is the variant.
`default_nettype none

package isa_pkg;

    typedef enum logic [1:0] {
        CLS_ADDSUB = 2'b00,
        CLS_BRANCH = 2'b01,
        CLS_SHIFT  = 2'b10,
        CLS_NONE   = 2'b11
    } op_class_t;

    // variant meaning depends on the class.
    typedef struct packed {
        op_class_t cls;
        logic      variant;
    } op_fields_t;

    typedef union packed {
        logic [2:0] raw;
        op_fields_t f;
    } op_u;

    typedef enum logic [2:0] {
        OP_ADD = 3'b000,
        OP_SUB = 3'b001,
        OP_CMP = 3'b010,
        OP_BR  = 3'b011,
        OP_SLL = 3'b100,
        OP_SRL = 3'b101
    } op_code_t;

    typedef enum logic [1:0] {
        BR_EQ = 2'b00,
        BR_NE = 2'b01,
        BR_LT = 2'b10,
        BR_GE = 2'b11
    } br_cond_t;

endpackage

`default_nettype wire

// File: verilog/uarch_pkg.sv
// data path types for the execute cluster.
// unit vectors use the fixed order alu0, alu1, shifter, branch.
`default_nettype none

`include "exec_defines.svh"

package uarch_pkg;

    typedef logic [`ROB_W-1:0]     rob_tag_t;
    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [`NUM_FU-1:0]    fu_vec_t;
    typedef logic [`NUM_SLOTS-1:0] slot_vec_t;

    // bit positions in fu_vec_t.
    localparam int FU_ALU0   = 0;
    localparam int FU_ALU1   = 1;
    localparam int FU_SHIFT  = 2;
    localparam int FU_BRANCH = 3;

endpackage

`default_nettype wire

// File: verilog/fu_scheduler.sv
// issues at most one ready slot per cycle to a free unit of its class.
// a consumed slot is masked for the cycle of its pulse; class 11 never issues.
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module fu_scheduler
    import isa_pkg::*;
    import uarch_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  slot_vec_t rs_valid,
    input  op_u       rs_op [`NUM_SLOTS],
    input  rob_tag_t  rs_rob [`NUM_SLOTS],
    input  br_cond_t  rs_cond [`NUM_SLOTS],
    input  word_t     rs_a [`NUM_SLOTS],
    input  word_t     rs_b [`NUM_SLOTS],
    input  fu_vec_t   fu_ready,
    output fu_vec_t   issue_vec,
    output rob_tag_t  issue_rob,
    output logic      issue_variant,
    output br_cond_t  issue_cond,
    output word_t     issue_a,
    output word_t     issue_b,
    output slot_vec_t consumed
);

    localparam int SLOT_IDX_W = $clog2(`NUM_SLOTS);

    slot_vec_t             consumed_q;
    slot_vec_t             eligible;
    slot_vec_t             issue_slot;
    logic                  sel_found;
    logic [SLOT_IDX_W-1:0] sel_idx;
    op_class_t             sel_cls;

    // lowest eligible slot wins.
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = `NUM_SLOTS - 1; i >= 0; i--) begin
            eligible[i] = rs_valid[i] && !consumed_q[i] && (rs_op[i].f.cls != CLS_NONE);
            if (eligible[i]) begin
                sel_found = 1'b1;
                sel_idx   = SLOT_IDX_W'(i);
            end
        end
    end

    assign sel_cls = rs_op[sel_idx].f.cls;

    // a busy target stalls issue, so later slots never pass the chosen one.
    always_comb begin
        issue_vec = '0;
        if (sel_found) begin
            case (sel_cls)
                CLS_ADDSUB: begin
                    if (fu_ready[FU_ALU0])
                        issue_vec[FU_ALU0] = 1'b1;
                    else if (fu_ready[FU_ALU1])
                        issue_vec[FU_ALU1] = 1'b1;
                end
                CLS_SHIFT:  issue_vec[FU_SHIFT]  = fu_ready[FU_SHIFT];
                CLS_BRANCH: issue_vec[FU_BRANCH] = fu_ready[FU_BRANCH];
                default:    issue_vec = '0;
            endcase
        end
    end

    always_comb begin
        issue_slot = '0;
        if (issue_vec != '0)
            issue_slot[sel_idx] = 1'b1;
    end

    assign issue_rob     = rs_rob[sel_idx];
    assign issue_variant = rs_op[sel_idx].f.variant;
    assign issue_cond    = rs_cond[sel_idx];
    assign issue_a       = rs_a[sel_idx];
    assign issue_b       = rs_b[sel_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            consumed_q <= '0;
        end else begin
            consumed_q <= issue_slot;
        end
    end

    assign consumed = consumed_q;

endmodule

`default_nettype wire

// File: verilog/alu_unit.sv
// single-cycle add/subtract unit.
// the result is held until granted, and the unit is not ready meanwhile.
`timescale 1ns/1ps
`default_nettype none

module alu_unit
    import uarch_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     valid_in,
    input  rob_tag_t rob,
    input  logic     variant,
    input  word_t    a,
    input  word_t    b,
    input  logic     grant,
    output logic     ready,
    output logic     res_valid,
    output rob_tag_t res_rob,
    output word_t    res_value
);

    logic     held;
    rob_tag_t rob_q;
    word_t    value_q;

    assign ready = !held;

    always_ff @(posedge clk) begin
        if (reset) begin
            held <= 1'b0;
        end else if (valid_in && ready) begin
            held <= 1'b1;
        end else if (grant) begin
            held <= 1'b0;
        end
    end

    // variant 1 subtracts.
    always_ff @(posedge clk) begin
        if (valid_in && ready) begin
            rob_q   <= rob;
            value_q <= variant ? (a - b) : (a + b);
        end
    end

    assign res_valid = held;
    assign res_rob   = rob_q;
    assign res_value = value_q;

endmodule

`default_nettype wire

// File: verilog/shift_unit.sv
// serial logical shifter, one bit position per cycle.
// latency is 1 + b[4:0] cycles; busy from acceptance until its grant.
`timescale 1ns/1ps
`default_nettype none

module shift_unit
    import uarch_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     valid_in,
    input  rob_tag_t rob,
    input  logic     variant,
    input  word_t    a,
    input  word_t    b,
    input  logic     grant,
    output logic     ready,
    output logic     res_valid,
    output rob_tag_t res_rob,
    output word_t    res_value
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SHIFT,
        S_HOLD
    } state_t;

    state_t     state;
    logic [4:0] count;
    logic       right_q;
    rob_tag_t   rob_q;
    word_t      value_q;

    assign ready = (state == S_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (valid_in) state <= (b[4:0] == 5'd0) ? S_HOLD : S_SHIFT;
                S_SHIFT: if (count == 5'd1) state <= S_HOLD;
                S_HOLD:  if (grant) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in && ready) begin
            count   <= b[4:0];
            right_q <= variant;
            rob_q   <= rob;
            value_q <= a;
        end else if (state == S_SHIFT) begin
            count   <= count - 5'd1;
            value_q <= right_q ? (value_q >> 1) : (value_q << 1);
        end
    end

    assign res_valid = (state == S_HOLD);
    assign res_rob   = rob_q;
    assign res_value = value_q;

endmodule

`default_nettype wire

// File: verilog/branch_unit.sv
// branch comparator; the result word is 1 when the condition holds, else 0.
// res_branch carries the variant, so compares report 0 and branches 1.
`timescale 1ns/1ps
`default_nettype none

module branch_unit
    import isa_pkg::*;
    import uarch_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     valid_in,
    input  rob_tag_t rob,
    input  logic     variant,
    input  br_cond_t cond,
    input  word_t    a,
    input  word_t    b,
    input  logic     grant,
    output logic     ready,
    output logic     res_valid,
    output rob_tag_t res_rob,
    output word_t    res_value,
    output logic     res_branch
);

    logic     held;
    logic     taken;
    logic     branch_q;
    rob_tag_t rob_q;
    word_t    value_q;

    // lt and ge compare signed.
    always_comb begin
        case (cond)
            BR_EQ:   taken = (a == b);
            BR_NE:   taken = (a != b);
            BR_LT:   taken = ($signed(a) < $signed(b));
            default: taken = ($signed(a) >= $signed(b));
        endcase
    end

    assign ready = !held;

    always_ff @(posedge clk) begin
        if (reset) begin
            held <= 1'b0;
        end else if (valid_in && ready) begin
            held <= 1'b1;
        end else if (grant) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in && ready) begin
            rob_q    <= rob;
            value_q  <= word_t'(taken);
            branch_q <= variant;
        end
    end

    assign res_valid  = held;
    assign res_rob    = rob_q;
    assign res_value  = value_q;
    assign res_branch = branch_q;

endmodule

`default_nettype wire

// File: verilog/result_arbiter.sv
// fixed-priority grant of one held result per cycle onto the bus.
// unit 0 has the highest priority; cdb_hold blocks every grant.
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module result_arbiter
    import uarch_pkg::*;
(
    input  fu_vec_t  res_valid,
    input  rob_tag_t res_rob [`NUM_FU],
    input  word_t    res_value [`NUM_FU],
    input  logic     res_branch,
    input  logic     cdb_hold,
    output fu_vec_t  grant,
    output logic     cdb_valid,
    output rob_tag_t cdb_rob,
    output word_t    cdb_value,
    output logic     cdb_branch
);

    fu_vec_t lowest;

    // isolate the lowest set bit.
    assign lowest = res_valid & (~res_valid + fu_vec_t'(1));
    assign grant  = cdb_hold ? '0 : lowest;

    always_comb begin
        cdb_rob   = '0;
        cdb_value = '0;
        for (int i = 0; i < `NUM_FU; i++) begin
            if (grant[i]) begin
                cdb_rob   = res_rob[i];
                cdb_value = res_value[i];
            end
        end
    end

    assign cdb_valid  = |grant;
    // only the branch unit flags a branch.
    assign cdb_branch = grant[FU_BRANCH] & res_branch;

endmodule

`default_nettype wire

// File: verilog/exec_cluster.sv
// execute stage: scheduler, two alus, a serial shifter, a branch unit and the bus arbiter.
// the caller drops or replaces a slot's valid at the end of its consumed cycle.
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module exec_cluster
    import isa_pkg::*;
    import uarch_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  slot_vec_t rs_valid,
    input  op_u       rs_op [`NUM_SLOTS],
    input  rob_tag_t  rs_rob [`NUM_SLOTS],
    input  br_cond_t  rs_cond [`NUM_SLOTS],
    input  word_t     rs_a [`NUM_SLOTS],
    input  word_t     rs_b [`NUM_SLOTS],
    input  logic      cdb_hold,
    output slot_vec_t consumed,
    output logic      cdb_valid,
    output rob_tag_t  cdb_rob,
    output word_t     cdb_value,
    output logic      cdb_branch
);

    fu_vec_t  issue_vec;
    fu_vec_t  fu_ready;
    fu_vec_t  res_valid;
    fu_vec_t  grant;
    rob_tag_t issue_rob;
    logic     issue_variant;
    br_cond_t issue_cond;
    word_t    issue_a;
    word_t    issue_b;
    rob_tag_t res_rob [`NUM_FU];
    word_t    res_value [`NUM_FU];
    logic     res_branch;

    fu_scheduler u_sched (
        .clk(clk), .reset(reset),
        .rs_valid(rs_valid), .rs_op(rs_op), .rs_rob(rs_rob),
        .rs_cond(rs_cond), .rs_a(rs_a), .rs_b(rs_b),
        .fu_ready(fu_ready),
        .issue_vec(issue_vec), .issue_rob(issue_rob), .issue_variant(issue_variant),
        .issue_cond(issue_cond), .issue_a(issue_a), .issue_b(issue_b),
        .consumed(consumed)
    );

    alu_unit u_alu0 (
        .clk(clk), .reset(reset), .valid_in(issue_vec[FU_ALU0]),
        .rob(issue_rob), .variant(issue_variant), .a(issue_a), .b(issue_b),
        .grant(grant[FU_ALU0]), .ready(fu_ready[FU_ALU0]),
        .res_valid(res_valid[FU_ALU0]), .res_rob(res_rob[FU_ALU0]),
        .res_value(res_value[FU_ALU0])
    );

    alu_unit u_alu1 (
        .clk(clk), .reset(reset), .valid_in(issue_vec[FU_ALU1]),
        .rob(issue_rob), .variant(issue_variant), .a(issue_a), .b(issue_b),
        .grant(grant[FU_ALU1]), .ready(fu_ready[FU_ALU1]),
        .res_valid(res_valid[FU_ALU1]), .res_rob(res_rob[FU_ALU1]),
        .res_value(res_value[FU_ALU1])
    );

    shift_unit u_shift (
        .clk(clk), .reset(reset), .valid_in(issue_vec[FU_SHIFT]),
        .rob(issue_rob), .variant(issue_variant), .a(issue_a), .b(issue_b),
        .grant(grant[FU_SHIFT]), .ready(fu_ready[FU_SHIFT]),
        .res_valid(res_valid[FU_SHIFT]), .res_rob(res_rob[FU_SHIFT]),
        .res_value(res_value[FU_SHIFT])
    );

    branch_unit u_branch (
        .clk(clk), .reset(reset), .valid_in(issue_vec[FU_BRANCH]),
        .rob(issue_rob), .variant(issue_variant), .cond(issue_cond),
        .a(issue_a), .b(issue_b),
        .grant(grant[FU_BRANCH]), .ready(fu_ready[FU_BRANCH]),
        .res_valid(res_valid[FU_BRANCH]), .res_rob(res_rob[FU_BRANCH]),
        .res_value(res_value[FU_BRANCH]), .res_branch(res_branch)
    );

    result_arbiter u_arb (
        .res_valid(res_valid), .res_rob(res_rob), .res_value(res_value),
        .res_branch(res_branch), .cdb_hold(cdb_hold),
        .grant(grant), .cdb_valid(cdb_valid), .cdb_rob(cdb_rob),
        .cdb_value(cdb_value), .cdb_branch(cdb_branch)
    );

endmodule

`default_nettype wire

// File: verification/exec_cluster_asserts.sv
// bound checks on the scheduler and the bus, attached to the cluster top.
// every check is skipped while reset is high.
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_asserts
    import uarch_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input slot_vec_t rs_valid,
    input fu_vec_t   issue_vec,
    input slot_vec_t consumed,
    input fu_vec_t   grant,
    input logic      cdb_valid,
    input logic      cdb_hold
);

    a_issue_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(issue_vec))
        else $error("issue_vec drives more than one unit");

    a_consumed_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(consumed))
        else $error("consumed marks more than one slot");

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
        else $error("grant selects more than one unit");

    // a consumed slot was valid and issued one cycle earlier.
    a_consumed_after_issue: assert property (@(posedge clk) disable iff (reset)
        (consumed != '0) |->
            ($past(issue_vec) != '0) && (($past(rs_valid) & consumed) == consumed))
        else $error("consumed pulse without an issue of that slot in the previous cycle");

    a_hold_blocks_bus: assert property (@(posedge clk) disable iff (reset)
        cdb_hold |-> !cdb_valid)
        else $error("cdb_valid high while cdb_hold is high");

endmodule

bind exec_cluster exec_cluster_asserts u_asserts (
    .clk(clk), .reset(reset), .rs_valid(rs_valid), .issue_vec(issue_vec),
    .consumed(consumed), .grant(grant), .cdb_valid(cdb_valid), .cdb_hold(cdb_hold)
);

`default_nettype wire

// File: verification/exec_cluster_tb.sv
// directed tests for the execute cluster with a reference model keyed by rob tag.
// rob tags must be unique among the results in flight within one test.
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module exec_cluster_tb
    import isa_pkg::*;
    import uarch_pkg::*;
;

    localparam int TIMEOUT = 200;
    localparam int NUM_TAGS = 1 << `ROB_W;

    logic      clk;
    logic      reset;
    slot_vec_t rs_valid;
    op_u       rs_op [`NUM_SLOTS];
    rob_tag_t  rs_rob [`NUM_SLOTS];
    br_cond_t  rs_cond [`NUM_SLOTS];
    word_t     rs_a [`NUM_SLOTS];
    word_t     rs_b [`NUM_SLOTS];
    logic      cdb_hold;
    slot_vec_t consumed;
    logic      cdb_valid;
    rob_tag_t  cdb_rob;
    word_t     cdb_value;
    logic      cdb_branch;

    int seed = 32'h708;
    int errors = 0;
    int checks = 0;
    int tests = 0;

    // expected results, indexed by rob tag.
    word_t               exp_value [NUM_TAGS];
    logic                exp_branch [NUM_TAGS];
    logic [NUM_TAGS-1:0] pending;
    rob_tag_t            last_rob;

    rob_tag_t  got_rob [$];
    word_t     got_value [$];
    logic      got_branch [$];
    slot_vec_t cons_log [$];

    exec_cluster uut (
        .clk(clk), .reset(reset),
        .rs_valid(rs_valid), .rs_op(rs_op), .rs_rob(rs_rob), .rs_cond(rs_cond),
        .rs_a(rs_a), .rs_b(rs_b), .cdb_hold(cdb_hold),
        .consumed(consumed), .cdb_valid(cdb_valid), .cdb_rob(cdb_rob),
        .cdb_value(cdb_value), .cdb_branch(cdb_branch)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // bus results are taken at the edge where they are granted.
    always @(posedge clk) begin
        if (!reset && cdb_valid) begin
            got_rob.push_back(cdb_rob);
            got_value.push_back(cdb_value);
            got_branch.push_back(cdb_branch);
            if (cdb_hold) begin
                $display("bus result seen while cdb_hold is high");
                errors++;
            end
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_tag(input string name, input rob_tag_t got, input rob_tag_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_slots(input string name, input slot_vec_t got, input slot_vec_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // expected result from the add/sub, shift and branch rules.
    function automatic word_t model(input op_u op, input br_cond_t c, input word_t a,
                                    input word_t b);
        logic hit;
        case (op.f.cls)
            CLS_ADDSUB: return op.f.variant ? a - b : a + b;
            CLS_SHIFT:  return op.f.variant ? a >> b[4:0] : a << b[4:0];
            default: begin
                case (c)
                    BR_EQ:   hit = (a == b);
                    BR_NE:   hit = (a != b);
                    BR_LT:   hit = ($signed(a) < $signed(b));
                    default: hit = ($signed(a) >= $signed(b));
                endcase
                return word_t'(hit);
            end
        endcase
    endfunction

    task automatic load_slot(input int s, input logic [2:0] code, input rob_tag_t tag,
                             input br_cond_t c, input word_t a, input word_t b);
        op_u op;
        op.raw      = code;
        rs_op[s]    = op;
        rs_rob[s]   = tag;
        rs_cond[s]  = c;
        rs_a[s]     = a;
        rs_b[s]     = b;
        rs_valid[s] = 1'b1;
        if (op.f.cls != CLS_NONE) begin
            exp_value[tag]  = model(op, c, a, b);
            exp_branch[tag] = (op.f.cls == CLS_BRANCH) && op.f.variant;
            pending[tag]    = 1'b1;
        end
    endtask

    task automatic take_results();
        rob_tag_t t;
        word_t    v;
        logic     br;
        while (got_rob.size() > 0) begin
            t  = got_rob.pop_front();
            v  = got_value.pop_front();
            br = got_branch.pop_front();
            last_rob = t;
            if (!pending[t]) begin
                $display("unexpected or repeated bus result for tag %h", t);
                errors++;
            end else begin
                check_word("cdb_value", v, exp_value[t]);
                check_flag("cdb_branch", br, exp_branch[t]);
                pending[t] = 1'b0;
            end
        end
    endtask

    // a loaded slot stays valid through its consumed cycle and is dropped after it.
    task automatic drain(input slot_vec_t loaded);
        slot_vec_t left;
        slot_vec_t drop;
        int        n;
        left = loaded;
        drop = '0;
        n    = 0;
        while ((left != '0 || drop != '0) && n < TIMEOUT) begin
            @(negedge clk);
            rs_valid &= ~drop;
            drop = '0;
            if (consumed != '0) begin
                cons_log.push_back(consumed);
                if ((consumed & ~left) != '0) begin
                    $display("slot consumed twice or without being loaded: %b", consumed);
                    errors++;
                end
                left &= ~consumed;
                drop  = consumed;
            end
            take_results();
            n++;
        end
        if (left != '0) begin
            $display("timeout: slots %b were never consumed", left);
            errors++;
        end
        rs_valid &= ~(left | drop);
    endtask

    task automatic wait_results(input string what);
        int n;
        n = 0;
        while (pending != '0 && n < TIMEOUT) begin
            @(negedge clk);
            take_results();
            n++;
        end
        if (pending != '0) begin
            $display("timeout: %s results for tags %h never reached the bus", what, pending);
            errors++;
            pending = '0;
        end
        repeat (4) @(negedge clk);
        take_results();
    endtask

    task automatic report_test(input string name, input int e0);
        tests++;
        if (errors == e0)
            $display("%s: ok", name);
        else
            $display("%s: %0d error(s)", name, errors - e0);
    endtask

    task automatic reset_then_addsub();
        int e0;
        e0 = errors;
        check_slots("consumed", consumed, '0);
        check_flag("cdb_valid", cdb_valid, 1'b0);
        load_slot(0, OP_ADD, 4'h3, BR_EQ, 32'h1234_0000, 32'h0000_5678);
        drain(4'b0001);
        wait_results("add");
        check_tag("cdb_rob", last_rob, 4'h3);
        load_slot(0, OP_SUB, 4'h5, BR_EQ, 32'h0000_0010, 32'h0000_0020);
        drain(4'b0001);
        wait_results("sub");
        check_tag("cdb_rob", last_rob, 4'h5);
        report_test("reset_addsub", e0);
    endtask

    task automatic slots_in_order();
        int e0;
        e0 = errors;
        cons_log.delete();
        load_slot(0, OP_ADD, 4'h1, BR_EQ, $random(seed), $random(seed));
        load_slot(1, OP_BR, 4'h2, BR_LT, $random(seed), $random(seed));
        load_slot(2, OP_SLL, 4'h3, BR_EQ, $random(seed), 32'd7);
        load_slot(3, OP_SUB, 4'h4, BR_EQ, $random(seed), $random(seed));
        drain(4'b1111);
        wait_results("slot order");
        if (cons_log.size() != `NUM_SLOTS) begin
            $display("expected 4 consumed pulses, saw %0d", cons_log.size());
            errors++;
        end else begin
            for (int i = 0; i < `NUM_SLOTS; i++)
                check_slots("consumed", cons_log[i], slot_vec_t'(1 << i));
        end
        report_test("slot_order", e0);
    endtask

    task automatic two_alus();
        int e0;
        e0 = errors;
        load_slot(0, OP_ADD, 4'h6, BR_EQ, $random(seed), $random(seed));
        load_slot(1, OP_SUB, 4'h7, BR_EQ, $random(seed), $random(seed));
        drain(4'b0011);
        wait_results("two alu");
        report_test("two_alus", e0);
    endtask

    task automatic shifts_and_class11();
        int        e0;
        slot_vec_t seen;
        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            load_slot(i % `NUM_SLOTS, i[0] ? OP_SRL : OP_SLL, rob_tag_t'(i + 8), BR_EQ,
                      $random(seed), $random(seed));
            drain(slot_vec_t'(1 << (i % `NUM_SLOTS)));
            wait_results("shift");
        end
        // class 11 must stay in its slot.
        seen = '0;
        load_slot(2, 3'b110, 4'hf, BR_EQ, 32'h1, 32'h1);
        for (int n = 0; n < TIMEOUT / 4; n++) begin
            @(negedge clk);
            seen |= consumed;
        end
        check_slots("consumed", seen, '0);
        rs_valid[2] = 1'b0;
        report_test("shifts", e0);
    endtask

    task automatic branch_conditions();
        int    e0;
        word_t a;
        word_t b;
        e0 = errors;
        for (int c = 0; c < 4; c++) begin
            for (int s = 0; s < `NUM_SLOTS; s++) begin
                a = $random(seed);
                b = s[1] ? a : word_t'($random(seed));
                load_slot(s, s[0] ? OP_BR : OP_CMP, rob_tag_t'(c * 4 + s), br_cond_t'(c),
                          a, b);
            end
            drain(4'b1111);
            wait_results("branch");
        end
        report_test("branches", e0);
    endtask

    task automatic bus_backpressure();
        int e0;
        e0 = errors;
        cdb_hold = 1'b1;
        load_slot(0, OP_ADD, 4'h1, BR_EQ, $random(seed), $random(seed));
        load_slot(1, OP_SUB, 4'h2, BR_EQ, $random(seed), $random(seed));
        load_slot(2, OP_SRL, 4'h3, BR_EQ, $random(seed), $random(seed));
        load_slot(3, OP_BR, 4'h4, BR_NE, $random(seed), $random(seed));
        drain(4'b1111);
        for (int n = 0; n < 40; n++) begin
            @(negedge clk);
            check_flag("cdb_valid", cdb_valid, 1'b0);
        end
        cdb_hold = 1'b0;
        wait_results("held");
        report_test("backpressure", e0);
    endtask

    initial begin
        reset    = 1'b1;
        rs_valid = '0;
        cdb_hold = 1'b0;
        pending  = '0;
        last_rob = '0;
        for (int s = 0; s < `NUM_SLOTS; s++) begin
            rs_op[s].raw = 3'b000;
            rs_rob[s]    = '0;
            rs_cond[s]   = BR_EQ;
            rs_a[s]      = '0;
            rs_b[s]      = '0;
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        reset_then_addsub();
        slots_in_order();
        two_alus();
        shifts_and_class11();
        branch_conditions();
        bus_backpressure();

        $display("tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
verilog/isa_pkg.sv
verilog/uarch_pkg.sv
verilog/fu_scheduler.sv
verilog/alu_unit.sv
verilog/shift_unit.sv
verilog/branch_unit.sv
verilog/result_arbiter.sv
verilog/exec_cluster.sv
verification/exec_cluster_asserts.sv
verification/exec_cluster_tb.sv
